// File: src/spi_tx_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi transmit constants: frame width, queue depth
// and width of the finished-frame counter.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef SPI_TX_MACROS_SVH
`define SPI_TX_MACROS_SVH

// bits per spi frame, sent msb first.
`define SPI_DPW 8

// bytes held in the transmit queue.
`define SPI_FIFO_DEPTH 4

// frames_o wraps at this width.
`define SPI_CNT_W 16

`endif

// File: src/spi_tx_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi transmit types: payload byte, register map
// and frame count.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "spi_tx_macros.svh"

package spi_tx_pkg;

  // one frame of payload.
  typedef logic [`SPI_DPW-1:0] byte_t;

  // host register addresses, 2 and 3 are unused.
  typedef enum logic [1:0] {
    REG_DATA  = 2'd0,  // queue a byte.
    REG_CLEAR = 2'd1   // zero the frame count.
  } reg_addr_e;

  // finished frames since reset or the last clear.
  typedef logic [`SPI_CNT_W-1:0] frame_cnt_t;

endpackage

// File: src/spi_tx_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame request link between decode, shifter and
// the result counter.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

interface spi_tx_if;

  logic              req;   // one-cycle frame start.
  spi_tx_pkg::byte_t data;  // valid with req.
  logic              rdy;   // one-cycle frame end.
  logic              busy;  // frame in flight.

  modport decode (
    output req,
    output data,
    input  busy
  );

  modport execute (
    input  req,
    input  data,
    output rdy,
    output busy
  );

  modport result (
    input  rdy
  );

endinterface

// File: src/spi_byte_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte queue, circular buffer with full and empty.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "spi_tx_macros.svh"

module spi_byte_fifo (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              push_i,
  input  spi_tx_pkg::byte_t data_i,
  input  logic              pop_i,
  output spi_tx_pkg::byte_t head_o,
  output logic              empty_o,
  output logic              full_o
);

  localparam int unsigned DEPTH = `SPI_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  spi_tx_pkg::byte_t mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              do_push;
  logic              do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign head_o  = mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // both or neither.
      endcase
    end
  end

endmodule

// File: src/spi_cmd_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host write decoder, queues bytes and launches one
// spi frame from the queue head when the shifter is free.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module spi_cmd_decode (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  wr_i,
  input  spi_tx_pkg::reg_addr_e addr_i,
  input  spi_tx_pkg::byte_t     wdata_i,
  output logic                  clear_o,
  output logic                  full_o,
  output logic                  empty_o,
  spi_tx_if.decode              tx
);

  logic              push;
  logic              launch;
  logic              launch_q;
  spi_tx_pkg::byte_t head;

  // data writes into a full queue are dropped.
  assign push    = wr_i && (addr_i == spi_tx_pkg::REG_DATA) && !full_o;
  assign clear_o = wr_i && (addr_i == spi_tx_pkg::REG_CLEAR);

  // busy rises one cycle after req, launch_q covers that gap.
  assign launch  = !empty_o && !tx.busy && !launch_q;

  assign tx.req  = launch;
  assign tx.data = head;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      launch_q <= 1'b0;
    end else begin
      launch_q <= launch;
    end
  end

  spi_byte_fifo u_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (push),
    .data_i  (wdata_i),
    .pop_i   (launch),  // head leaves the queue as the frame starts.
    .head_o  (head),
    .empty_o (empty_o),
    .full_o  (full_o)
  );

endmodule

// File: src/spi_shifter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi serializer, one byte per request, msb first,
// idle-high clock, data changes on the falling edge.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "spi_tx_macros.svh"

module spi_shifter (
  input  logic       clk_i,
  input  logic       rst_ni,
  spi_tx_if.execute  tx,
  output logic       spi_o,
  output logic       spi_clk_o,
  output logic       spi_csb_o
);

  typedef enum logic [1:0] {IDLE, LOAD, TX, TOGGLE} state_e;

  state_e              state_q;
  spi_tx_pkg::byte_t   shift_q;
  logic [`SPI_DPW-1:0] bit_cnt_q;  // thermometer, one bit per rising edge.
  logic                rdy_q;
  logic                busy_q;

  assign spi_o   = shift_q[`SPI_DPW-1];
  assign tx.rdy  = rdy_q;
  assign tx.busy = busy_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      shift_q   <= '0;
      bit_cnt_q <= '0;
      spi_clk_o <= 1'b1;
      spi_csb_o <= 1'b1;
      rdy_q     <= 1'b0;
      busy_q    <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          spi_clk_o <= 1'b1;
          spi_csb_o <= !tx.req;  // select falls the cycle after req.
          busy_q    <= tx.req;   // also drops busy after rdy.
          rdy_q     <= 1'b0;
          bit_cnt_q <= '0;
          if (tx.req) begin
            shift_q <= tx.data;
            state_q <= LOAD;
          end
        end
        LOAD: begin
          spi_clk_o <= 1'b0;  // first fall keeps the msb on the line.
          state_q   <= TX;
        end
        TX: begin
          spi_clk_o <= 1'b1;
          bit_cnt_q <= {bit_cnt_q[`SPI_DPW-2:0], 1'b1};
          state_q   <= TOGGLE;
        end
        TOGGLE: begin
          if (&bit_cnt_q) begin
            // last clock-high phase done, end the frame.
            spi_csb_o <= 1'b1;
            rdy_q     <= 1'b1;
            shift_q   <= '0;
            state_q   <= IDLE;
          end else begin
            spi_clk_o <= 1'b0;
            shift_q   <= {shift_q[`SPI_DPW-2:0], 1'b0};  // next bit on the fall.
            state_q   <= TX;
          end
        end
        default: begin
          shift_q   <= '0;
          bit_cnt_q <= '0;
          spi_clk_o <= 1'b1;
          spi_csb_o <= 1'b1;
          rdy_q     <= 1'b0;
          busy_q    <= 1'b0;
          state_q   <= IDLE;
        end
      endcase
    end
  end

endmodule

// File: src/spi_frame_tally.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// finished-frame counter and queue drain detection.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module spi_frame_tally (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   empty_i,
  spi_tx_if.result               tx,
  output spi_tx_pkg::frame_cnt_t frames_o,
  output logic                   done_o
);

  spi_tx_pkg::frame_cnt_t frames_q;
  logic                   done_q;

  assign frames_o = frames_q;
  assign done_o   = done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      frames_q <= '0;
      done_q   <= 1'b0;
    end else begin
      if (clear_i) begin
        frames_q <= '0;  // clear wins over a finishing frame.
      end else if (tx.rdy) begin
        frames_q <= frames_q + 1'b1;  // wraps.
      end
      // last queued frame just ended.
      done_q <= tx.rdy && empty_i;
    end
  end

endmodule

// File: src/spi_tx_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi transmit peripheral, write-only host port to
// a queued msb-first spi master.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "spi_tx_macros.svh"

module spi_tx_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  wr_i,
  input  logic [1:0]            addr_i,
  input  logic [`SPI_DPW-1:0]   wdata_i,
  output logic                  spi_o,
  output logic                  spi_clk_o,
  output logic                  spi_csb_o,
  output logic                  busy_o,
  output logic                  full_o,
  output logic                  done_o,
  output logic [`SPI_CNT_W-1:0] frames_o
);

  spi_tx_pkg::reg_addr_e addr;
  logic                  clear;
  logic                  empty;

  spi_tx_if tx ();

  assign addr   = spi_tx_pkg::reg_addr_e'(addr_i);
  assign busy_o = tx.busy;

  spi_cmd_decode u_decode (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wr_i    (wr_i),
    .addr_i  (addr),
    .wdata_i (wdata_i),
    .clear_o (clear),
    .full_o  (full_o),
    .empty_o (empty),
    .tx      (tx.decode)
  );

  spi_shifter u_shifter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .tx        (tx.execute),
    .spi_o     (spi_o),
    .spi_clk_o (spi_clk_o),
    .spi_csb_o (spi_csb_o)
  );

  spi_frame_tally u_tally (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear),
    .empty_i  (empty),
    .tx       (tx.result),
    .frames_o (frames_o),
    .done_o   (done_o)
  );

endmodule

// File: bench/spi_tx_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random host writes to the spi transmit peripheral
// checked against a cycle model and a line monitor.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "spi_tx_macros.svh"

module spi_tx_tb;

  localparam int NUM_OPS   = 60;
  localparam int FRAME_CYC = 2 * `SPI_DPW + 2;  // req to rdy.
  localparam int MAX_GAP   = 40;
  localparam int LIMIT_CYC = 2 * NUM_OPS * 2 * FRAME_CYC + NUM_OPS * MAX_GAP + 500;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  wr_i;
  logic [1:0]            addr_i;
  logic [`SPI_DPW-1:0]   wdata_i;
  logic                  spi_o;
  logic                  spi_clk_o;
  logic                  spi_csb_o;
  logic                  busy_o;
  logic                  full_o;
  logic                  done_o;
  logic [`SPI_CNT_W-1:0] frames_o;

  logic [`SPI_DPW-1:0]   exp_q [$];  // accepted bytes not yet seen on the line.
  int                    m_occ;
  int                    m_age;      // cycles since req or -1 when idle.
  logic                  m_launch_q;
  logic [`SPI_CNT_W-1:0] m_frames;
  logic                  m_done;
  logic [`SPI_DPW-1:0]   mon_byte;
  int                    mon_bits;

  spi_tx_top dut_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wr_i      (wr_i),
    .addr_i    (addr_i),
    .wdata_i   (wdata_i),
    .spi_o     (spi_o),
    .spi_clk_o (spi_clk_o),
    .spi_csb_o (spi_csb_o),
    .busy_o    (busy_o),
    .full_o    (full_o),
    .done_o    (done_o),
    .frames_o  (frames_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic stop_on_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("test failed");
    $fatal(1, "Fail %s got 0x%h expected 0x%h", name, got, exp);
  endtask

  task automatic stop_with_reason(input string why);
    $display("test failed");
    $fatal(1, "%s", why);
  endtask

  task automatic idle_cycle();
    @(posedge clk_i);
    #10;
    wr_i = 1'b0;
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [`SPI_DPW-1:0] data);
    @(posedge clk_i);
    #10;
    wr_i    = 1'b1;
    addr_i  = addr;
    wdata_i = data;
  endtask

  task automatic wait_drain();
    idle_cycle();
    while (m_occ != 0 || m_age != -1 || busy_o !== 1'b0) begin
      idle_cycle();
    end
  endtask

  // the model runs at the falling clock where inputs and outputs are settled.
  always @(negedge clk_i) begin : cycle_model
    logic busy_m;
    logic empty_m;
    logic full_m;
    logic rdy;
    logic launch;
    logic push;
    logic clear;
    logic csb_m;
    logic sclk_m;
    if (!rst_ni) begin
      m_occ      = 0;
      m_age      = -1;
      m_launch_q = 1'b0;
      m_frames   = '0;
      m_done     = 1'b0;
    end else begin
      busy_m  = (m_age >= 1);
      empty_m = (m_occ == 0);
      full_m  = (m_occ == `SPI_FIFO_DEPTH);
      rdy     = (m_age == FRAME_CYC);
      launch  = !empty_m && !busy_m && !m_launch_q;
      push    = wr_i && (addr_i == spi_tx_pkg::REG_DATA) && !full_m;
      clear   = wr_i && (addr_i == spi_tx_pkg::REG_CLEAR);
      csb_m   = !(m_age >= 1 && m_age < FRAME_CYC);
      sclk_m  = !(m_age >= 2 && m_age < FRAME_CYC - 1 && m_age % 2 == 0);
      assert (busy_o === busy_m) else stop_on_value("busy_o", busy_o, busy_m);
      assert (full_o === full_m) else stop_on_value("full_o", full_o, full_m);
      assert (done_o === m_done) else stop_on_value("done_o", done_o, m_done);
      assert (frames_o === m_frames) else stop_on_value("frames_o", frames_o, m_frames);
      assert (spi_csb_o === csb_m) else stop_on_value("spi_csb_o", spi_csb_o, csb_m);
      assert (spi_clk_o === sclk_m) else stop_on_value("spi_clk_o", spi_clk_o, sclk_m);
      if (csb_m) begin
        assert (spi_o === 1'b0) else stop_on_value("spi_o", spi_o, 1'b0);
      end
      if (push) begin
        exp_q.push_back(wdata_i);
      end
      m_occ = m_occ + (push ? 1 : 0) - (launch ? 1 : 0);
      m_done = rdy && empty_m;  // drain seen with the queue state of the rdy cycle.
      if (clear) begin
        m_frames = '0;
      end else if (rdy) begin
        m_frames = m_frames + 1'b1;
      end
      if (launch) begin
        m_age = 1;
      end else if (m_age >= 1 && m_age < FRAME_CYC) begin
        m_age++;
      end else begin
        m_age = -1;
      end
      m_launch_q = launch;
    end
  end

  always @(negedge spi_csb_o) begin
    mon_bits = 0;
    mon_byte = '0;
  end

  always @(posedge spi_clk_o) begin
    if (spi_csb_o === 1'b0) begin
      mon_byte = {mon_byte[`SPI_DPW-2:0], spi_o};  // msb arrives first.
      mon_bits++;
    end
  end

  always @(posedge spi_csb_o) begin : frame_check
    logic [`SPI_DPW-1:0] exp_byte;
    if (rst_ni === 1'b1) begin
      assert (mon_bits == `SPI_DPW) else stop_on_value("spi_clk_o edges", mon_bits, `SPI_DPW);
      assert (exp_q.size() > 0) else stop_with_reason("a frame was sent with no byte queued");
      exp_byte = exp_q.pop_front();
      assert (mon_byte === exp_byte) else stop_on_value("spi_o frame", mon_byte, exp_byte);
    end
  end

  initial begin : watchdog
    #(LIMIT_CYC * 100);
    stop_with_reason("watchdog expired before the run completed");
  end

  initial begin : stimulus
    int         gap;
    int         pick;
    logic [1:0] addr;
    void'($urandom(19475));
    mon_bits   = 0;
    mon_byte   = '0;
    rst_ni     = 1'b0;
    wr_i       = 1'b0;
    addr_i     = '0;
    wdata_i    = '0;
    repeat (4) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    repeat (3) idle_cycle();  // reset values checked by the model.
    for (int i = 0; i < NUM_OPS; i++) begin
      if ($urandom % 4 == 0) begin
        gap = $urandom % MAX_GAP;
      end else begin
        gap = $urandom % 3;  // short gaps fill the queue.
      end
      repeat (gap) idle_cycle();
      pick = $urandom % 100;
      if (pick < 70) begin
        addr = spi_tx_pkg::REG_DATA;
      end else if (pick < 85) begin
        addr = spi_tx_pkg::REG_CLEAR;
      end else begin
        addr = 2'd2 + 2'($urandom % 2);
      end
      write_reg(addr, `SPI_DPW'($urandom));
    end
    wait_drain();
    // one byte into an idle queue and a clear landing on its rdy cycle
    write_reg(spi_tx_pkg::REG_DATA, `SPI_DPW'($urandom));
    repeat (FRAME_CYC) idle_cycle();
    write_reg(spi_tx_pkg::REG_CLEAR, '0);
    wait_drain();
    repeat (2) idle_cycle();
    assert (exp_q.size() == 0) else stop_with_reason("queued bytes never left on the line");
    $display("test passed");
    $finish;
  end

endmodule

// File: files.f
+incdir+src
src/spi_tx_pkg.sv
src/spi_tx_if.sv
src/spi_byte_fifo.sv
src/spi_cmd_decode.sv
src/spi_shifter.sv
src/spi_frame_tally.sv
src/spi_tx_top.sv
bench/spi_tx_tb.sv
